/* Bender.yml */
package:
  name: npu

sources:
  - hdl/npu_cfg_pkg.sv
  - hdl/npu_op_pkg.sv
  - hdl/npu_stage_if.sv
  - hdl/npu_issue.sv
  - hdl/npu_mvu.sv
  - hdl/npu_mfu.sv
  - hdl/npu_top.sv
  - target: simulation
    files:
      - verification/npu_checker.sv
      - verification/npu_tb.sv

/* filelist.f */
hdl/npu_cfg_pkg.sv
hdl/npu_op_pkg.sv
hdl/npu_stage_if.sv
hdl/npu_issue.sv
hdl/npu_mvu.sv
hdl/npu_mfu.sv
hdl/npu_top.sv
verification/npu_checker.sv
verification/npu_tb.sv

/* hdl/npu_cfg_pkg.sv */
package npu_cfg_pkg;

    // ****************************
    // Datapath widths
    // ****************************
    localparam int IN_W  = 8;   // Input element and weight
    localparam int ACC_W = 24;  // Accumulator and result element

    // Signed input lane and matrix weight
    typedef logic signed [IN_W-1:0] in_elem_t;

    // Signed accumulator lane
    // Also the width of every stage-to-stage lane
    typedef logic signed [ACC_W-1:0] acc_elem_t;

    // ****************************
    // Default sizing
    // ****************************
    localparam int NUM_LANES_DEF   = 4;  // Lanes per vector, also matrix rows and cols
    localparam int IN_DEPTH_DEF    = 4;  // Command FIFO entries
    localparam int OUT_CREDITS_DEF = 4;  // Results the sink can hold

endpackage

/* hdl/npu_issue.sv */
`timescale 1ns/100ps

module npu_issue #(
    parameter int NUM_LANES   = npu_cfg_pkg::NUM_LANES_DEF,
    parameter int IN_DEPTH    = npu_cfg_pkg::IN_DEPTH_DEF,
    parameter int OUT_CREDITS = npu_cfg_pkg::OUT_CREDITS_DEF
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  in_valid,   // Spends one sender credit
    input  npu_cfg_pkg::in_elem_t [NUM_LANES-1:0] in_vec,
    input  npu_op_pkg::mfu_op_e                   in_op0,
    input  npu_op_pkg::act_e                      in_act0,
    input  npu_op_pkg::mfu_op_e                   in_op1,
    input  npu_op_pkg::act_e                      in_act1,
    output logic                                  in_credit,  // One credit back per pop
    input  logic                                  out_credit, // Sink freed one slot
    npu_stage_if.src                              issue
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    typedef logic [PTR_W-1:0] ptr_t;  // FIFO slot index
    typedef logic [CNT_W-1:0] cnt_t;  // FIFO fill level
    typedef logic [CRD_W-1:0] crd_t;  // Output credits held

    // Command storage
    npu_cfg_pkg::in_elem_t [NUM_LANES-1:0] vec_mem [IN_DEPTH];
    npu_op_pkg::mfu_op_e                   op0_mem [IN_DEPTH];
    npu_op_pkg::act_e                      act0_mem [IN_DEPTH];
    npu_op_pkg::mfu_op_e                   op1_mem [IN_DEPTH];
    npu_op_pkg::act_e                      act1_mem [IN_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t fill;
    crd_t credits;
    logic full;
    logic push;
    logic pop;

    // Wrap at IN_DEPTH, depth need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (fill == cnt_t'(IN_DEPTH));
    assign push = in_valid && !full;                // Overflow only on sender error
    assign pop  = (fill != '0) && (credits != '0);  // Reserve a sink slot before issue

    // ****************************
    // FIFO write
    // ****************************
    always_ff @(posedge clk) begin
        if (push) begin
            vec_mem[wr_ptr]  <= in_vec;
            op0_mem[wr_ptr]  <= in_op0;
            act0_mem[wr_ptr] <= in_act0;
            op1_mem[wr_ptr]  <= in_op1;
            act1_mem[wr_ptr] <= in_act1;
        end
    end

    // Pointers, fill level and both credit sides
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            credits   <= crd_t'(OUT_CREDITS);  // Sink starts empty
            in_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fill      <= fill + cnt_t'(push) - cnt_t'(pop);
            credits   <= credits - crd_t'(pop) + crd_t'(out_credit);
            in_credit <= pop;  // One cycle after the entry leaves
        end
    end

    // ****************************
    // Issue beat, same cycle as pop
    // ****************************
    always_comb begin
        issue.valid = pop;
        for (int l = 0; l < NUM_LANES; l++) begin
            issue.data[l] = npu_cfg_pkg::acc_elem_t'($signed(vec_mem[rd_ptr][l]));  // Sign-extend
        end
        issue.op0  = op0_mem[rd_ptr];
        issue.act0 = act0_mem[rd_ptr];
        issue.op1  = op1_mem[rd_ptr];
        issue.act1 = act1_mem[rd_ptr];
    end

    // Sender keeps within its IN_DEPTH credits
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> !full)
        else $error("in_valid while command FIFO full");

    // Sink never returns more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= crd_t'(OUT_CREDITS))
        else $error("output credit count above OUT_CREDITS");

endmodule

/* hdl/npu_mfu.sv */
`timescale 1ns/100ps

module npu_mfu #(
    parameter int NUM_LANES = npu_cfg_pkg::NUM_LANES_DEF,
    parameter int STAGE     = 0   // 0 uses op0/act0, 1 uses op1/act1
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         opd_we,    // Only while pipeline idle
    input  logic [$clog2(NUM_LANES)-1:0] opd_lane,
    input  npu_cfg_pkg::in_elem_t        opd_data,
    npu_stage_if.dst                     vin,
    npu_stage_if.src                     vout
);

    // Operand vector for this stage
    npu_cfg_pkg::in_elem_t opd [NUM_LANES];

    npu_op_pkg::mfu_op_e                    op_sel;
    npu_op_pkg::act_e                       act_sel;
    npu_cfg_pkg::acc_elem_t [NUM_LANES-1:0] alu_res;
    npu_cfg_pkg::acc_elem_t [NUM_LANES-1:0] act_res;

    always_ff @(posedge clk) begin
        if (opd_we) begin
            opd[opd_lane] <= opd_data;
        end
    end

    assign op_sel  = (STAGE == 0) ? vin.op0 : vin.op1;
    assign act_sel = (STAGE == 0) ? vin.act0 : vin.act1;

    // ****************************
    // Lane ALU and activation
    // ****************************
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            case (op_sel)
                npu_op_pkg::MFU_ADD:
                    alu_res[l] = $signed(vin.data[l]) + npu_cfg_pkg::acc_elem_t'(opd[l]);
                npu_op_pkg::MFU_MUL:
                    alu_res[l] = $signed(vin.data[l]) * npu_cfg_pkg::acc_elem_t'(opd[l]);
                default:
                    alu_res[l] = vin.data[l];  // PASS
            endcase
            // ReLU on sign bit
            if (act_sel == npu_op_pkg::ACT_RELU && alu_res[l][npu_cfg_pkg::ACC_W-1]) begin
                act_res[l] = '0;
            end else begin
                act_res[l] = alu_res[l];
            end
        end
    end

    // One register per stage
    always_ff @(posedge clk) begin
        vout.data <= act_res;
        vout.op0  <= vin.op0;   // Forward both pairs
        vout.act0 <= vin.act0;
        vout.op1  <= vin.op1;
        vout.act1 <= vin.act1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vout.valid <= 1'b0;
        end else begin
            vout.valid <= vin.valid;
        end
    end

endmodule

/* hdl/npu_mvu.sv */
`timescale 1ns/100ps

module npu_mvu #(
    parameter int NUM_LANES = npu_cfg_pkg::NUM_LANES_DEF
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           mrf_we,    // Only while pipeline idle
    input  logic [$clog2(NUM_LANES)-1:0]   mrf_row,
    input  logic [$clog2(NUM_LANES)-1:0]   mrf_col,
    input  npu_cfg_pkg::in_elem_t          mrf_data,
    npu_stage_if.dst                       vin,
    npu_stage_if.src                       vout
);

    // Matrix register file, weight[row][col]
    npu_cfg_pkg::in_elem_t weight [NUM_LANES][NUM_LANES];

    npu_cfg_pkg::acc_elem_t                 prod [NUM_LANES][NUM_LANES];  // Cycle 1 products
    npu_cfg_pkg::acc_elem_t [NUM_LANES-1:0] row_sum;
    logic                                   prod_valid;

    // Op fields riding along with the products
    npu_op_pkg::mfu_op_e op0_q;
    npu_op_pkg::act_e    act0_q;
    npu_op_pkg::mfu_op_e op1_q;
    npu_op_pkg::act_e    act1_q;

    always_ff @(posedge clk) begin
        if (mrf_we) begin
            weight[mrf_row][mrf_col] <= mrf_data;
        end
    end

    // ****************************
    // Cycle 1 products
    // ****************************
    always_ff @(posedge clk) begin
        for (int r = 0; r < NUM_LANES; r++) begin
            for (int c = 0; c < NUM_LANES; c++) begin
                prod[r][c] <= npu_cfg_pkg::acc_elem_t'(weight[r][c])
                              * $signed(vin.data[c]);  // Low ACC_W bits kept
            end
        end
        op0_q  <= vin.op0;
        act0_q <= vin.act0;
        op1_q  <= vin.op1;
        act1_q <= vin.act1;
    end

    // Row reduction, wraps modulo 2^ACC_W
    always_comb begin
        for (int r = 0; r < NUM_LANES; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < NUM_LANES; c++) begin
                row_sum[r] = row_sum[r] + prod[r][c];
            end
        end
    end

    // ****************************
    // Cycle 2 sums
    // ****************************
    always_ff @(posedge clk) begin
        vout.data <= row_sum;
        vout.op0  <= op0_q;
        vout.act0 <= act0_q;
        vout.op1  <= op1_q;
        vout.act1 <= act1_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            vout.valid <= 1'b0;
        end else begin
            prod_valid <= vin.valid;
            vout.valid <= prod_valid;  // Two cycles behind vin
        end
    end

    // Issued command carries fully known lanes
    a_vin_known: assert property (@(posedge clk) disable iff (!arst_n)
        vin.valid |-> !$isunknown(vin.data))
        else $error("MVU input beat with unknown data");

endmodule

/* hdl/npu_op_pkg.sv */
package npu_op_pkg;

    // ****************************
    // MFU operation per stage
    // ****************************
    typedef enum logic [1:0] {
        MFU_PASS = 2'd0,  // Forward unchanged
        MFU_ADD  = 2'd1,  // Add operand lane
        MFU_MUL  = 2'd2   // Multiply by operand lane
    } mfu_op_e;

    // Activation after the operation
    typedef enum logic {
        ACT_NONE = 1'b0,
        ACT_RELU = 1'b1   // Clamp negatives to zero
    } act_e;

endpackage

/* hdl/npu_stage_if.sv */
`timescale 1ns/100ps

// One pipeline beat between stages
// No ready signal since the pipeline never stalls
interface npu_stage_if #(
    parameter int NUM_LANES = npu_cfg_pkg::NUM_LANES_DEF
);
    logic                                  valid;  // Beat taken every cycle it is high
    npu_cfg_pkg::acc_elem_t [NUM_LANES-1:0] data;
    npu_op_pkg::mfu_op_e                   op0;    // For MFU stage 0
    npu_op_pkg::act_e                      act0;
    npu_op_pkg::mfu_op_e                   op1;    // For MFU stage 1
    npu_op_pkg::act_e                      act1;

    // Producing stage
    modport src (output valid, data, op0, act0, op1, act1);

    // Consuming stage
    modport dst (input valid, data, op0, act0, op1, act1);

endinterface

/* hdl/npu_top.sv */
`timescale 1ns/100ps

module npu_top #(
    parameter int NUM_LANES   = npu_cfg_pkg::NUM_LANES_DEF,
    parameter int IN_DEPTH    = npu_cfg_pkg::IN_DEPTH_DEF,
    parameter int OUT_CREDITS = npu_cfg_pkg::OUT_CREDITS_DEF
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    // Command input
    input  logic                                   in_valid,
    input  npu_cfg_pkg::in_elem_t [NUM_LANES-1:0]  in_vec,
    input  npu_op_pkg::mfu_op_e                    in_op0,
    input  npu_op_pkg::act_e                       in_act0,
    input  npu_op_pkg::mfu_op_e                    in_op1,
    input  npu_op_pkg::act_e                       in_act1,
    output logic                                   in_credit,
    // Matrix load
    input  logic                                   mrf_we,
    input  logic [$clog2(NUM_LANES)-1:0]           mrf_row,
    input  logic [$clog2(NUM_LANES)-1:0]           mrf_col,
    input  npu_cfg_pkg::in_elem_t                  mrf_data,
    // Operand load
    input  logic                                   opd_we,
    input  logic                                   opd_stage,  // 0 or 1
    input  logic [$clog2(NUM_LANES)-1:0]           opd_lane,
    input  npu_cfg_pkg::in_elem_t                  opd_data,
    // Result output
    output logic                                   out_valid,
    output npu_cfg_pkg::acc_elem_t [NUM_LANES-1:0] out_vec,
    input  logic                                   out_credit
);

    logic opd_we0;
    logic opd_we1;

    // ****************************
    // Stage links
    // ****************************
    npu_stage_if #(.NUM_LANES(NUM_LANES)) issue_if ();  // Issue to MVU
    npu_stage_if #(.NUM_LANES(NUM_LANES)) mvu_if ();    // MVU to MFU 0
    npu_stage_if #(.NUM_LANES(NUM_LANES)) mfu0_if ();   // MFU 0 to MFU 1
    npu_stage_if #(.NUM_LANES(NUM_LANES)) res_if ();    // MFU 1 result

    // Route operand writes by stage
    assign opd_we0 = opd_we && (opd_stage == 1'b0);
    assign opd_we1 = opd_we && (opd_stage == 1'b1);

    npu_issue #(
        .NUM_LANES  (NUM_LANES),
        .IN_DEPTH   (IN_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) issue_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_vec    (in_vec),
        .in_op0    (in_op0),
        .in_act0   (in_act0),
        .in_op1    (in_op1),
        .in_act1   (in_act1),
        .in_credit (in_credit),
        .out_credit(out_credit),
        .issue     (issue_if.src)
    );

    npu_mvu #(.NUM_LANES(NUM_LANES)) mvu_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .mrf_we  (mrf_we),
        .mrf_row (mrf_row),
        .mrf_col (mrf_col),
        .mrf_data(mrf_data),
        .vin     (issue_if.dst),
        .vout    (mvu_if.src)
    );

    npu_mfu #(.NUM_LANES(NUM_LANES), .STAGE(0)) mfu0_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .opd_we  (opd_we0),
        .opd_lane(opd_lane),
        .opd_data(opd_data),
        .vin     (mvu_if.dst),
        .vout    (mfu0_if.src)
    );

    npu_mfu #(.NUM_LANES(NUM_LANES), .STAGE(1)) mfu1_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .opd_we  (opd_we1),
        .opd_lane(opd_lane),
        .opd_data(opd_data),
        .vin     (mfu0_if.dst),
        .vout    (res_if.src)
    );

    // Four cycles after issue
    assign out_valid = res_if.valid;
    assign out_vec   = res_if.data;

endmodule

/* verification/npu_checker.sv */
`timescale 1ns/100ps

module npu_checker #(
    parameter int NUM_LANES   = npu_cfg_pkg::NUM_LANES_DEF,
    parameter int IN_DEPTH    = npu_cfg_pkg::IN_DEPTH_DEF,
    parameter int OUT_CREDITS = npu_cfg_pkg::OUT_CREDITS_DEF
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   in_valid,
    input  npu_cfg_pkg::in_elem_t [NUM_LANES-1:0]  in_vec,
    input  npu_op_pkg::mfu_op_e                    in_op0,
    input  npu_op_pkg::act_e                       in_act0,
    input  npu_op_pkg::mfu_op_e                    in_op1,
    input  npu_op_pkg::act_e                       in_act1,
    input  logic                                   in_credit,
    input  logic                                   mrf_we,
    input  logic [$clog2(NUM_LANES)-1:0]           mrf_row,
    input  logic [$clog2(NUM_LANES)-1:0]           mrf_col,
    input  npu_cfg_pkg::in_elem_t                  mrf_data,
    input  logic                                   opd_we,
    input  logic                                   opd_stage,
    input  logic [$clog2(NUM_LANES)-1:0]           opd_lane,
    input  npu_cfg_pkg::in_elem_t                  opd_data,
    input  logic                                   out_valid,
    input  npu_cfg_pkg::acc_elem_t [NUM_LANES-1:0] out_vec,
    input  logic                                   out_credit,
    input  logic                                   run_done,   // Stimulus finished and pipeline drained
    output int                                     err_count,
    output int                                     cmd_count,  // Accepted commands
    output int                                     res_count   // out_valid beats
);

    typedef npu_cfg_pkg::acc_elem_t [NUM_LANES-1:0] vec_t;

    npu_cfg_pkg::in_elem_t w_m [NUM_LANES][NUM_LANES];  // Mirror of the matrix
    npu_cfg_pkg::in_elem_t opd_m [2][NUM_LANES];        // Mirror of both operand vectors
    vec_t exp_q[$];                                     // Expected results in command order
    int   crd_ret;      // out_credit pulses so far
    int   in_crd_cnt;   // in_credit pulses so far
    bit   final_done;
    int   m_fill;       // Modeled FIFO level
    int   m_cred;       // Modeled output credits
    bit   m_pop;        // Modeled issue this cycle
    bit   [3:0] pop_hist;  // Past issues, bit 0 one cycle ago

    // One MFU stage on one lane kept to ACC_W bits
    function automatic npu_cfg_pkg::acc_elem_t stage_model(
        input npu_cfg_pkg::acc_elem_t x,
        input npu_op_pkg::mfu_op_e    op,
        input npu_op_pkg::act_e       act,
        input npu_cfg_pkg::in_elem_t  k
    );
        longint                 t;
        npu_cfg_pkg::acc_elem_t y;
        case (op)
            npu_op_pkg::MFU_ADD: t = longint'(x) + longint'(k);
            npu_op_pkg::MFU_MUL: t = longint'(x) * longint'(k);
            default:             t = longint'(x);
        endcase
        y = t[npu_cfg_pkg::ACC_W-1:0];
        if (act == npu_op_pkg::ACT_RELU && y < 0) begin
            y = '0;  // Negative clamps to zero
        end
        return y;
    endfunction

    // Full datapath for one command
    function automatic vec_t expect_vec(
        input npu_cfg_pkg::in_elem_t [NUM_LANES-1:0] v,
        input npu_op_pkg::mfu_op_e op0,
        input npu_op_pkg::act_e    act0,
        input npu_op_pkg::mfu_op_e op1,
        input npu_op_pkg::act_e    act1
    );
        vec_t   res;
        longint acc;
        for (int r = 0; r < NUM_LANES; r++) begin
            acc = 0;
            for (int c = 0; c < NUM_LANES; c++) begin
                acc += longint'(w_m[r][c]) * longint'(v[c]);
            end
            res[r] = acc[npu_cfg_pkg::ACC_W-1:0];  // Modulo 2^24
            res[r] = stage_model(res[r], op0, act0, opd_m[0][r]);
            res[r] = stage_model(res[r], op1, act1, opd_m[1][r]);
        end
        return res;
    endfunction

    // ****************************
    // Result comparison
    // ****************************
    task automatic check_result();
        vec_t exp_v;
        res_count++;
        if (exp_q.size() == 0) begin
            err_count++;
            $display("Result beat %0d arrived with no command outstanding", res_count);
        end else begin
            exp_v = exp_q.pop_front();
            if (out_vec !== exp_v) begin
                err_count++;
                $display("[FAIL] out_vec = %h, expected %h (beat %0d)", out_vec, exp_v, res_count);
            end
        end
        if (res_count > OUT_CREDITS + crd_ret) begin  // Sink overrun
            err_count++;
            $display("Result beat %0d sent without an output credit", res_count);
        end
    endtask

    task automatic final_checks();
        if (exp_q.size() != 0) begin
            err_count++;
            $display("%0d expected results never appeared", exp_q.size());
        end
        if (in_crd_cnt != cmd_count) begin
            err_count++;
            $display("[FAIL] in_credit pulses = %h, expected %h", in_crd_cnt, cmd_count);
        end
    endtask

    // ****************************
    // Issue timing model
    // ****************************
    task automatic check_issue();
        m_pop = (m_fill > 0) && (m_cred > 0);  // Queued entry and a sink slot
        if (in_credit !== pop_hist[0]) begin
            err_count++;
            $display("[FAIL] in_credit = %h, expected %h", in_credit, pop_hist[0]);
        end
        if (out_valid !== pop_hist[3]) begin
            err_count++;  // Four cycles after issue
            $display("[FAIL] out_valid = %h, expected %h", out_valid, pop_hist[3]);
        end
        if (in_valid && m_fill == IN_DEPTH) begin
            err_count++;
            $display("Command sent while the command FIFO was full");
        end
        pop_hist = {pop_hist[2:0], m_pop};
        if (in_valid && m_fill < IN_DEPTH) m_fill++;
        if (m_pop) begin
            m_fill--;
            m_cred--;
        end
        if (out_credit) m_cred++;
    endtask

    // Sampled mid-cycle when all signals are settled
    always @(negedge clk) begin
        if (!arst_n) begin
            err_count  = 0;
            cmd_count  = 0;
            res_count  = 0;
            crd_ret    = 0;
            in_crd_cnt = 0;
            final_done = 1'b0;
            m_fill     = 0;
            m_cred     = OUT_CREDITS;  // Sink starts empty
            m_pop      = 1'b0;
            pop_hist   = '0;
            exp_q.delete();
        end else begin
            if (mrf_we) w_m[mrf_row][mrf_col] = mrf_data;
            if (opd_we) opd_m[opd_stage][opd_lane] = opd_data;
            if (cmd_count == 0 && (out_valid !== 1'b0 || in_credit !== 1'b0)) begin
                err_count++;  // Idle outputs must stay low
                $display("[FAIL] out_valid = %h, in_credit = %h, expected 0 before first command",
                         out_valid, in_credit);
            end
            if (out_valid) check_result();
            if (in_valid) begin
                exp_q.push_back(expect_vec(in_vec, in_op0, in_act0, in_op1, in_act1));
                cmd_count++;
            end
            if (in_credit) in_crd_cnt++;
            if (out_credit) crd_ret++;  // Counted after the bound check
            check_issue();
            if (run_done && !final_done) begin
                final_checks();
                final_done = 1'b1;
            end
        end
    end

endmodule

/* verification/npu_tb.sv */
`timescale 1ns/100ps

module npu_tb;

    localparam int NUM_LANES   = npu_cfg_pkg::NUM_LANES_DEF;
    localparam int IN_DEPTH    = npu_cfg_pkg::IN_DEPTH_DEF;
    localparam int OUT_CREDITS = npu_cfg_pkg::OUT_CREDITS_DEF;
    localparam int IDX_W       = $clog2(NUM_LANES);
    localparam int N_CMDS      = 200;
    localparam int LOAD_CYC    = NUM_LANES * NUM_LANES + 2 * NUM_LANES + 20;
    localparam int MAX_CYCLES  = N_CMDS * 20 + 3 * LOAD_CYC;  // Three load phases

    logic                                   clk = 1'b0;
    logic                                   arst_n;
    logic                                   in_valid;
    npu_cfg_pkg::in_elem_t [NUM_LANES-1:0]  in_vec;
    npu_op_pkg::mfu_op_e                    in_op0;
    npu_op_pkg::act_e                       in_act0;
    npu_op_pkg::mfu_op_e                    in_op1;
    npu_op_pkg::act_e                       in_act1;
    logic                                   in_credit;
    logic                                   mrf_we;
    logic [IDX_W-1:0]                       mrf_row;
    logic [IDX_W-1:0]                       mrf_col;
    npu_cfg_pkg::in_elem_t                  mrf_data;
    logic                                   opd_we;
    logic                                   opd_stage;
    logic [IDX_W-1:0]                       opd_lane;
    npu_cfg_pkg::in_elem_t                  opd_data;
    logic                                   out_valid;
    npu_cfg_pkg::acc_elem_t [NUM_LANES-1:0] out_vec;
    logic                                   out_credit;
    logic                                   run_done;
    int                                     err_count;
    int                                     cmd_count;
    int                                     res_count;

    int seed_ret;
    int in_cred;    // Sender credits on hand
    int held;       // Results sitting in the sink
    int n_sent;
    int n_results;
    int cycles = 0;

    always #2 clk = ~clk;  // 4 ns period

    npu_top #(
        .NUM_LANES  (NUM_LANES),
        .IN_DEPTH   (IN_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) dut_i (.*);

    npu_checker #(
        .NUM_LANES  (NUM_LANES),
        .IN_DEPTH   (IN_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) checker_i (.*);

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // ****************************
    // Per-cycle driver and sink
    // ****************************
    task automatic step();
        @(posedge clk);
        #0.5;
        in_valid = 1'b0;
        mrf_we   = 1'b0;
        opd_we   = 1'b0;
        if (in_credit) in_cred++;
        if (out_valid) begin
            held++;
            n_results++;
        end
        // Sink stalls for 40 of every 150 cycles
        if (held > 0 && (cycles % 150) < 110 && $urandom_range(1, 0) == 1) begin
            out_credit = 1'b1;
            held--;
        end else begin
            out_credit = 1'b0;
        end
    endtask

    task automatic load_all();
        for (int r = 0; r < NUM_LANES; r++) begin
            for (int c = 0; c < NUM_LANES; c++) begin
                step();
                mrf_we   = 1'b1;
                mrf_row  = IDX_W'(r);
                mrf_col  = IDX_W'(c);
                mrf_data = npu_cfg_pkg::in_elem_t'($urandom);
            end
        end
        for (int s = 0; s < 2; s++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                step();
                opd_we    = 1'b1;
                opd_stage = s[0];
                opd_lane  = IDX_W'(l);
                opd_data  = npu_cfg_pkg::in_elem_t'($urandom);
            end
        end
        step();  // Last write lands
    endtask

    task automatic send_cmds(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            step();
            if (in_cred > 0 && $urandom_range(3, 0) != 0) begin
                in_valid = 1'b1;
                for (int l = 0; l < NUM_LANES; l++) begin
                    in_vec[l] = npu_cfg_pkg::in_elem_t'($urandom);
                end
                in_op0  = npu_op_pkg::mfu_op_e'($urandom_range(2, 0));
                in_act0 = npu_op_pkg::act_e'($urandom_range(1, 0));
                in_op1  = npu_op_pkg::mfu_op_e'($urandom_range(2, 0));
                in_act1 = npu_op_pkg::act_e'($urandom_range(1, 0));
                in_cred--;
                sent++;
                n_sent++;
            end
        end
    endtask

    task automatic drain();
        while (n_results < n_sent) begin
            step();
        end
    endtask

    initial begin
        seed_ret   = $urandom(32'hcba0db76);
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_vec     = '0;
        in_op0     = npu_op_pkg::MFU_PASS;
        in_act0    = npu_op_pkg::ACT_NONE;
        in_op1     = npu_op_pkg::MFU_PASS;
        in_act1    = npu_op_pkg::ACT_NONE;
        mrf_we     = 1'b0;
        mrf_row    = '0;
        mrf_col    = '0;
        mrf_data   = '0;
        opd_we     = 1'b0;
        opd_stage  = 1'b0;
        opd_lane   = '0;
        opd_data   = '0;
        out_credit = 1'b0;
        run_done   = 1'b0;
        in_cred    = IN_DEPTH;
        held       = 0;
        n_sent     = 0;
        n_results  = 0;
        repeat (3) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        repeat (6) step();  // Idle outputs watched here
        for (int p = 0; p < 3; p++) begin
            load_all();
            send_cmds((p == 2) ? N_CMDS - 2 * (N_CMDS / 3) : N_CMDS / 3);
            drain();
        end
        repeat (4) step();  // Trailing in_credit pulses
        run_done = 1'b1;
        repeat (2) step();
        $display("Commands %0d, results %0d, errors %0d", cmd_count, res_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
